/* dv/scv_bus_tb.sv */
// testbench for the console bus core, drives the cpu side and checks returns against its own model
module scv_bus_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned VALID_WAIT  = 8;   // cycles allowed for a read return
  localparam int unsigned WINDOW_WAIT = 400;
  localparam int unsigned CPU_CYCLE   = 14;
  localparam int unsigned AUD_WINDOW  = 105;
  localparam int unsigned AUD_HITS    = 22;

  typedef enum logic [2:0] {AREA_ROM, AREA_WRAM, AREA_VDC, AREA_APU, AREA_CART, AREA_OPEN} area_e;

  logic        CLK, rst_i;
  logic [15:0] cpu_addr_i;
  logic [7:0]  cpu_wdata_i, cpu_rdata_o, rominit_data_i, ext_rdata_i;
  logic        cpu_rd_i, cpu_wr_i, cpu_rdata_valid_o, rominit_valid_i;
  logic [11:0] rominit_addr_i;
  logic        vdc_sel_o, apu_sel_o, cart_sel_o;
  logic        cp1_rise_o, cp1_fall_o, cp2_rise_o, cp2_fall_o, vdc_ce_o, aud_ce_o;

  logic [7:0]  rom_model [4096];
  logic [7:0]  ram_model [128];
  logic        exp_valid, win_done;
  logic [7:0]  exp_rdata;
  int unsigned reads_seen, since_rst, phase, win_pos, win_cnt, win_total, windows_seen;
  area_e       cur_area;
  logic [31:0] lfsr_state = 32'h917a_2fb0;
  logic [11:0] rom_addrs [$]; // addresses loaded, read back later

  scv_bus #(.ROM_AW(12), .WRAM_AW(7)) i_scv_bus (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic area_e area_of(input logic [15:0] addr);
    if (addr <= 16'h0FFF) return AREA_ROM;
    else if (addr >= 16'hFF80) return AREA_WRAM;
    else if (addr >= 16'h8000) return AREA_CART;
    else if (addr >= 16'h2000 && addr <= 16'h35FF) return AREA_VDC;
    else if (addr >= 16'h3600 && addr <= 16'h37FF) return AREA_APU;
    else return AREA_OPEN;
  endfunction

  function automatic logic [7:0] expected_read(input logic [15:0] addr, input logic [7:0] ext);
    case (area_of(addr))
      AREA_ROM:  return rom_model[addr[11:0]];
      AREA_WRAM: return ram_model[addr[6:0]];
      AREA_OPEN: return 8'hFF; // open bus
      default:   return ext;
    endcase
  endfunction

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int unsigned k = 0; k < n; k++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    fail_run($sformatf("ERROR %s: got 0x%0h expected 0x%0h", name, got, want));
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic wait_read_valid();
    int unsigned n;
    n = 0;
    while (!cpu_rdata_valid_o) begin
      if (n == VALID_WAIT) fail_run("timeout waiting for cpu_rdata_valid_o");
      else begin
        next_cycle();
        n++;
      end
    end
  endtask

  task automatic cpu_read(input logic [15:0] addr);
    logic [31:0] r;
    r           = take_bits(8);
    cpu_addr_i  = addr;
    ext_rdata_i = r[7:0];
    cpu_rd_i    = 1'b1;
    cpu_wr_i    = 1'b0;
    next_cycle();
    cpu_rd_i    = 1'b0;
    ext_rdata_i = ~ext_rdata_i; // peripheral byte moves on after the read cycle
    wait_read_valid();
  endtask

  task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
    cpu_addr_i  = addr;
    cpu_wdata_i = data;
    cpu_wr_i    = 1'b1;
    cpu_rd_i    = 1'b0;
    next_cycle();
    cpu_wr_i    = 1'b0;
  endtask

  task automatic rom_load(input logic [11:0] addr, input logic [7:0] data);
    rominit_addr_i  = addr;
    rominit_data_i  = data;
    rominit_valid_i = 1'b1;
    next_cycle();
    rominit_valid_i = 1'b0;
  endtask

  ////////////////////
  // reference model
  ////////////////////

  always @(posedge CLK) begin
    if (rominit_valid_i) rom_model[rominit_addr_i] <= rominit_data_i;
    if (cpu_wr_i && area_of(cpu_addr_i) == AREA_WRAM) ram_model[cpu_addr_i[6:0]] <= cpu_wdata_i;
    if (cpu_rd_i) exp_rdata <= expected_read(cpu_addr_i, ext_rdata_i);
    exp_valid <= rst_i ? 1'b0 : cpu_rd_i;
    if (exp_valid) reads_seen <= reads_seen + 1;
  end

  always @(posedge CLK) begin
    if (rst_i) begin
      since_rst    <= 0;
      win_pos      <= 0;
      win_cnt      <= 0;
      win_done     <= 1'b0;
      windows_seen <= 0;
    end else begin
      since_rst <= since_rst + 1;
      win_done  <= 1'b0;
      if (win_pos == AUD_WINDOW - 1) begin
        win_total    <= aud_ce_o ? win_cnt + 1 : win_cnt;
        win_done     <= 1'b1;
        win_pos      <= 0;
        win_cnt      <= 0;
        windows_seen <= windows_seen + 1;
      end else begin
        win_pos <= win_pos + 1;
        win_cnt <= aud_ce_o ? win_cnt + 1 : win_cnt;
      end
    end
  end

  always_comb phase = since_rst % CPU_CYCLE; // 0 in the first cycle out of reset
  always_comb cur_area = area_of(cpu_addr_i);

  ////////////////////
  // checks
  ////////////////////

  valid_chk : assert property (@(posedge CLK) disable iff (rst_i) cpu_rdata_valid_o == exp_valid)
    else report_mismatch("cpu_rdata_valid_o", 32'(cpu_rdata_valid_o), 32'(exp_valid));
  rdata_chk : assert property (@(posedge CLK) disable iff (rst_i)
    !exp_valid || cpu_rdata_o == exp_rdata)
    else report_mismatch("cpu_rdata_o", 32'(cpu_rdata_o), 32'(exp_rdata));
  vdc_sel_chk : assert property (@(posedge CLK) vdc_sel_o == (cur_area == AREA_VDC))
    else report_mismatch("vdc_sel_o", 32'(vdc_sel_o), 32'(cur_area == AREA_VDC));
  apu_sel_chk : assert property (@(posedge CLK) apu_sel_o == (cur_area == AREA_APU))
    else report_mismatch("apu_sel_o", 32'(apu_sel_o), 32'(cur_area == AREA_APU));
  cart_sel_chk : assert property (@(posedge CLK) cart_sel_o == (cur_area == AREA_CART))
    else report_mismatch("cart_sel_o", 32'(cart_sel_o), 32'(cur_area == AREA_CART));
  cp2_fall_chk : assert property (@(posedge CLK) disable iff (rst_i) cp2_fall_o == (phase == 0))
    else report_mismatch("cp2_fall_o", 32'(cp2_fall_o), 32'(phase == 0));
  cp1_rise_chk : assert property (@(posedge CLK) disable iff (rst_i) cp1_rise_o == (phase == 2))
    else report_mismatch("cp1_rise_o", 32'(cp1_rise_o), 32'(phase == 2));
  cp1_fall_chk : assert property (@(posedge CLK) disable iff (rst_i) cp1_fall_o == (phase == 4))
    else report_mismatch("cp1_fall_o", 32'(cp1_fall_o), 32'(phase == 4));
  cp2_rise_chk : assert property (@(posedge CLK) disable iff (rst_i) cp2_rise_o == (phase == 6))
    else report_mismatch("cp2_rise_o", 32'(cp2_rise_o), 32'(phase == 6));
  vdc_ce_chk : assert property (@(posedge CLK) disable iff (rst_i)
    vdc_ce_o == (phase == 2 || phase == 9))
    else report_mismatch("vdc_ce_o", 32'(vdc_ce_o), 32'(phase == 2 || phase == 9));
  aud_rate_chk : assert property (@(posedge CLK) disable iff (rst_i)
    !win_done || win_total == AUD_HITS)
    else report_mismatch("aud_ce_o count", 32'(win_total), 32'(AUD_HITS));

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    int          i;
    int unsigned n;
    logic [31:0] r, s;
    logic [15:0] a;
    cpu_addr_i      = '0;
    cpu_wdata_i     = '0;
    cpu_rd_i        = 1'b0;
    cpu_wr_i        = 1'b0;
    rominit_addr_i  = '0;
    rominit_data_i  = '0;
    rominit_valid_i = 1'b0;
    ext_rdata_i     = '0;
    rst_i = 1'b1;
    repeat (3) @(posedge CLK);
    #1;
    rst_i = 1'b0;

    for (i = 0; i < 128; i++) begin // every ram byte gets a known value
      r = take_bits(8);
      cpu_write(16'hFF80 + 16'(i), r[7:0]);
    end

    // rom load, edges of the rom first
    r = take_bits(8);
    rom_load(12'h000, r[7:0]);
    r = take_bits(8);
    rom_load(12'hFFF, r[7:0]);
    rom_addrs.push_back(12'h000);
    rom_addrs.push_back(12'hFFF);
    for (i = 0; i < 24; i++) begin
      r = take_bits(12);
      s = take_bits(8);
      rom_load(r[11:0], s[7:0]);
      rom_addrs.push_back(r[11:0]);
    end
    rom_load(12'h5A5, 8'h3C);
    cpu_read(16'h05A5); // loaded in the cycle before
    foreach (rom_addrs[k]) cpu_read({4'h0, rom_addrs[k]});
    cpu_write({4'h0, rom_addrs[2]}, ~rom_model[rom_addrs[2]]);
    cpu_read({4'h0, rom_addrs[2]});

    for (i = 0; i < 64; i++) begin
      r = take_bits(1);
      s = take_bits(7);
      a = 16'hFF80 | {9'd0, s[6:0]};
      if (r[0]) begin
        s = take_bits(8);
        cpu_write(a, s[7:0]);
      end
      cpu_read(a);
    end

    // peripherals, boundaries then random
    cpu_read(16'h2000);
    cpu_read(16'h35FF);
    cpu_read(16'h3600);
    cpu_read(16'h37FF);
    cpu_read(16'h8000);
    cpu_read(16'hFF7F);
    for (i = 0; i < 12; i++) begin
      s = take_bits(16);
      cpu_read(16'h2000 + (s[15:0] % 16'h1600));
      s = take_bits(9);
      cpu_read(16'h3600 + {7'd0, s[8:0]});
      s = take_bits(15);
      cpu_read(16'h8000 + (s[15:0] % 16'h7F80));
      s = take_bits(14);
      cpu_read(16'h4000 + {2'd0, s[13:0]});
    end
    cpu_read(16'h1000);
    cpu_read(16'h1FFF);
    cpu_read(16'h3800);
    cpu_read(16'h7FFF);

    cpu_addr_i = 16'h1000;
    n = 0;
    while (windows_seen < 2) begin
      if (n == WINDOW_WAIT) fail_run("timeout waiting for two audio windows");
      else begin
        next_cycle();
        n++;
      end
    end

    if (reads_seen == 0) fail_run("no read returns were checked");
    else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

/* hdl/address_decoder.sv */
// cpu address decode into a region code and the chip selects of the bus
module address_decoder #(
  parameter int unsigned ROM_AW  = 12,
  parameter int unsigned WRAM_AW = 7
) (
  input  scv_map_pkg::bus_addr_u cpu_addr_i,
  output logic                   rom_sel_o,
  output logic                   wram_sel_o,
  output logic                   vdc_sel_o,
  output logic                   apu_sel_o,
  output logic                   cart_sel_o,
  output scv_map_pkg::region_e   region_o
);

  // rom size in pages, never decoded past the rom space of the map
  localparam int unsigned ROM_PAGES = 1 << (ROM_AW - 9);
  localparam int unsigned ROM_SPAN  = (ROM_PAGES < scv_map_pkg::ROM_LIMIT) ?
                                      ROM_PAGES : scv_map_pkg::ROM_LIMIT;
  // address bits above the work ram offset
  localparam int unsigned WRAM_HI_W = 16 - WRAM_AW;

  logic [6:0] page;

  assign page = cpu_addr_i.page.page;

  ////////////////////
  // chip selects
  ////////////////////

  assign rom_sel_o  = (page < 7'(ROM_SPAN));
  assign wram_sel_o = &cpu_addr_i.ram.high[8 -: WRAM_HI_W]; // top window, 0xff80 up
  assign vdc_sel_o  = (page >= scv_map_pkg::VDC_PAGE_FIRST) &&
                      (page <= scv_map_pkg::VDC_PAGE_LAST);
  assign apu_sel_o  = (page == scv_map_pkg::APU_PAGE);
  assign cart_sel_o = cpu_addr_i.ram.high[8] && !wram_sel_o; // upper half minus the ram

  ////////////////////
  // region code
  ////////////////////

  always_comb begin
    if (rom_sel_o) begin
      region_o = scv_map_pkg::ROM;
    end else if (wram_sel_o) begin
      region_o = scv_map_pkg::WRAM;
    end else if (vdc_sel_o) begin
      region_o = scv_map_pkg::VDC;
    end else if (apu_sel_o) begin
      region_o = scv_map_pkg::APU;
    end else if (cart_sel_o) begin
      region_o = scv_map_pkg::CART;
    end else begin
      region_o = scv_map_pkg::NONE; // holes such as 0x1000
    end
  end

  // the map constants must keep every region apart
  always_comb begin
    sel_onehot_a : assert ($onehot0({rom_sel_o, wram_sel_o, vdc_sel_o, apu_sel_o, cart_sel_o}))
      else $error("overlapping selects for cpu_addr_i 0x%h", cpu_addr_i);
  end

endmodule

/* hdl/boot_rom.sv */
// internal boot rom, filled through the byte-wide init port and read by the cpu
module boot_rom #(
  parameter int unsigned ROM_AW = 12
) (
  input  logic              CLK,
  input  logic [ROM_AW-1:0] rominit_addr_i,
  input  logic [7:0]        rominit_data_i,
  input  logic              rominit_valid_i, // one byte per cycle while high
  input  logic              rd_i,            // cpu read, already gated by the rom select
  input  logic [ROM_AW-1:0] addr_i,
  output logic [7:0]        rdata_o
);

  localparam int unsigned DEPTH = 1 << ROM_AW;

  logic [7:0] mem [DEPTH];

  ////////////////////
  // init port
  ////////////////////

  // the cpu side has no write path, so bus writes never reach here
  always_ff @(posedge CLK) begin
    if (rominit_valid_i) begin
      mem[rominit_addr_i] <= rominit_data_i;
    end
  end

  ////////////////////
  // cpu read
  ////////////////////

  always_ff @(posedge CLK) begin
    if (rd_i) begin
      rdata_o <= mem[addr_i]; // held until the next rom read
    end
  end

endmodule

/* hdl/clock_enable_gen.sv */
// master-clock divider giving the cpu phase strobes and the video and audio clock enables
module clock_enable_gen (
  input  logic CLK,
  input  logic rst_i,
  output logic cp1_rise_o, // phase 1 rising edge
  output logic cp1_fall_o, // phase 1 falling edge
  output logic cp2_rise_o, // phase 2 rising edge
  output logic cp2_fall_o, // phase 2 falling edge
  output logic vdc_ce_o,
  output logic aud_ce_o
);

  localparam int unsigned CNT_W = $clog2(scv_clk_pkg::CPU_DIV);
  localparam int unsigned ACC_W = $clog2(scv_clk_pkg::AUD_MUL + scv_clk_pkg::AUD_DIV);

  logic [CNT_W-1:0] div_cnt;     // position inside the cpu cycle
  logic [ACC_W-1:0] aud_acc;     // fractional remainder
  logic [ACC_W-1:0] aud_acc_sum;

  ////////////////////
  // cpu cycle counter
  ////////////////////

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      div_cnt <= '0;
    end else if (div_cnt == CNT_W'(scv_clk_pkg::CPU_DIV - 1)) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign cp2_fall_o = (div_cnt == CNT_W'(scv_clk_pkg::CP2_FALL_AT));
  assign cp1_rise_o = (div_cnt == CNT_W'(scv_clk_pkg::CP1_RISE_AT));
  assign cp1_fall_o = (div_cnt == CNT_W'(scv_clk_pkg::CP1_FALL_AT));
  assign cp2_rise_o = (div_cnt == CNT_W'(scv_clk_pkg::CP2_RISE_AT));

  assign vdc_ce_o = (div_cnt == CNT_W'(scv_clk_pkg::VDC_AT_A)) |
                    (div_cnt == CNT_W'(scv_clk_pkg::VDC_AT_B));

  ////////////////////
  // audio accumulator
  ////////////////////

  // fires whenever the remainder would overflow the denominator
  assign aud_acc_sum = aud_acc + ACC_W'(scv_clk_pkg::AUD_MUL);
  assign aud_ce_o    = (aud_acc_sum >= ACC_W'(scv_clk_pkg::AUD_DIV));

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      aud_acc <= '0;
    end else if (aud_ce_o) begin
      aud_acc <= aud_acc_sum - ACC_W'(scv_clk_pkg::AUD_DIV);
    end else begin
      aud_acc <= aud_acc_sum;
    end
  end

  // remainder must stay below the denominator or the rate drifts
  aud_acc_range_a : assert property (@(posedge CLK) disable iff (rst_i)
    aud_acc < ACC_W'(scv_clk_pkg::AUD_DIV))
    else $error("aud_acc out of range: 0x%h", aud_acc);

endmodule

/* hdl/read_data_mux.sv */
// read-data combiner returning the byte of the region a cpu read addressed, one cycle later
module read_data_mux (
  input  logic                 CLK,
  input  logic                 rst_i,
  input  logic                 rd_i,
  input  scv_map_pkg::region_e region_i,
  input  logic [7:0]           ext_rdata_i,  // peripherals, sampled with the read
  input  logic [7:0]           rom_rdata_i,
  input  logic [7:0]           wram_rdata_i,
  output logic [7:0]           rdata_o,
  output logic                 rdata_valid_o
);

  logic                 rd_q;
  scv_map_pkg::region_e region_q;
  logic [7:0]           ext_q;

  ////////////////////
  // read capture
  ////////////////////

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= rd_i;
    end
  end

  // region and peripheral byte of the read in flight
  always_ff @(posedge CLK) begin
    if (rd_i) begin
      region_q <= region_i;
      ext_q    <= ext_rdata_i;
    end
  end

  ////////////////////
  // return path
  ////////////////////

  always_comb begin
    case (region_q)
      scv_map_pkg::ROM:  rdata_o = rom_rdata_i;
      scv_map_pkg::WRAM: rdata_o = wram_rdata_i;
      scv_map_pkg::VDC,
      scv_map_pkg::APU,
      scv_map_pkg::CART: rdata_o = ext_q;
      default:           rdata_o = 8'hff; // nothing answers, bus floats high
    endcase
  end

  assign rdata_valid_o = rd_q;

endmodule

/* hdl/scv_bus.sv */
// top of the console system-bus core, place it between the cpu and the peripherals
module scv_bus #(
  parameter int unsigned ROM_AW  = 12,
  parameter int unsigned WRAM_AW = 7
) (
  input  logic              CLK,
  input  logic              rst_i,

  // cpu bus
  input  logic [15:0]       cpu_addr_i,
  input  logic [7:0]        cpu_wdata_i,
  input  logic              cpu_rd_i,
  input  logic              cpu_wr_i,
  output logic [7:0]        cpu_rdata_o,
  output logic              cpu_rdata_valid_o,

  // boot rom load
  input  logic [ROM_AW-1:0] rominit_addr_i,
  input  logic [7:0]        rominit_data_i,
  input  logic              rominit_valid_i,

  // external peripherals
  input  logic [7:0]        ext_rdata_i,
  output logic              vdc_sel_o,
  output logic              apu_sel_o,
  output logic              cart_sel_o,

  // clock strobes
  output logic              cp1_rise_o,
  output logic              cp1_fall_o,
  output logic              cp2_rise_o,
  output logic              cp2_fall_o,
  output logic              vdc_ce_o,
  output logic              aud_ce_o
);

  logic                 rom_sel;
  logic                 wram_sel;
  logic                 rom_rd;
  scv_map_pkg::region_e region;
  logic [7:0]           rom_rdata;
  logic [7:0]           wram_rdata;

  ////////////////////
  // clocking
  ////////////////////

  clock_enable_gen i_clock_enable_gen (
    .CLK        (CLK),
    .rst_i      (rst_i),
    .cp1_rise_o (cp1_rise_o),
    .cp1_fall_o (cp1_fall_o),
    .cp2_rise_o (cp2_rise_o),
    .cp2_fall_o (cp2_fall_o),
    .vdc_ce_o   (vdc_ce_o),
    .aud_ce_o   (aud_ce_o)
  );

  ////////////////////
  // decode and memories
  ////////////////////

  address_decoder #(
    .ROM_AW  (ROM_AW),
    .WRAM_AW (WRAM_AW)
  ) i_address_decoder (
    .cpu_addr_i (cpu_addr_i),
    .rom_sel_o  (rom_sel),
    .wram_sel_o (wram_sel),
    .vdc_sel_o  (vdc_sel_o),
    .apu_sel_o  (apu_sel_o),
    .cart_sel_o (cart_sel_o),
    .region_o   (region)
  );

  assign rom_rd = cpu_rd_i & rom_sel; // rom output only moves on its own reads

  boot_rom #(
    .ROM_AW (ROM_AW)
  ) i_boot_rom (
    .CLK             (CLK),
    .rominit_addr_i  (rominit_addr_i),
    .rominit_data_i  (rominit_data_i),
    .rominit_valid_i (rominit_valid_i),
    .rd_i            (rom_rd),
    .addr_i          (cpu_addr_i[ROM_AW-1:0]),
    .rdata_o         (rom_rdata)
  );

  work_ram #(
    .WRAM_AW (WRAM_AW)
  ) i_work_ram (
    .CLK     (CLK),
    .sel_i   (wram_sel),
    .rd_i    (cpu_rd_i),
    .wr_i    (cpu_wr_i),
    .addr_i  (cpu_addr_i[WRAM_AW-1:0]),
    .wdata_i (cpu_wdata_i),
    .rdata_o (wram_rdata)
  );

  ////////////////////
  // read return
  ////////////////////

  read_data_mux i_read_data_mux (
    .CLK           (CLK),
    .rst_i         (rst_i),
    .rd_i          (cpu_rd_i),
    .region_i      (region),
    .ext_rdata_i   (ext_rdata_i),
    .rom_rdata_i   (rom_rdata),
    .wram_rdata_i  (wram_rdata),
    .rdata_o       (cpu_rdata_o),
    .rdata_valid_o (cpu_rdata_valid_o)
  );

endmodule

/* hdl/scv_clk_pkg.sv */
// clock ratios of the console, used by the clock-enable generator
package scv_clk_pkg;

  // master clock is twice the video crystal, about 28.64 MHz

  ////////////////////
  // cpu two-phase clock
  ////////////////////

  localparam int unsigned CPU_DIV = 14; // master clocks per cpu cycle

  // divide counter values where each phase edge is flagged
  localparam int unsigned CP2_FALL_AT = 0;
  localparam int unsigned CP1_RISE_AT = 2;
  localparam int unsigned CP1_FALL_AT = 4;
  localparam int unsigned CP2_RISE_AT = 6;

  ////////////////////
  // video and audio
  ////////////////////

  // video runs at master / 7, so two pulses per cpu cycle
  localparam int unsigned VDC_AT_A = 2;
  localparam int unsigned VDC_AT_B = 9;

  // audio enable at master * 22 / 105, which lands on 6 MHz
  localparam int unsigned AUD_MUL = 22;
  localparam int unsigned AUD_DIV = 105;

endpackage

/* hdl/scv_map_pkg.sv */
// address map of the console bus, shared by the decoder, the read combiner and the top level
package scv_map_pkg;

  ////////////////////
  // address word views
  ////////////////////

  // peripheral decode works on 512-byte pages
  typedef struct packed {
    logic [6:0] page;   // addr[15:9]
    logic [8:0] offset; // byte within the page
  } page_view_t;

  // work ram sits in the topmost 128 bytes
  typedef struct packed {
    logic [8:0] high;   // all ones inside the ram window
    logic [6:0] offset; // byte within the work ram
  } ram_view_t;

  typedef union packed {
    page_view_t page;
    ram_view_t  ram;
  } bus_addr_u;

  ////////////////////
  // regions
  ////////////////////

  typedef enum logic [2:0] {
    ROM  = 3'd0, // internal boot rom
    WRAM = 3'd1, // internal work ram
    VDC  = 3'd2, // video controller registers and vram
    APU  = 3'd3, // sound processor port
    CART = 3'd4, // cartridge space
    NONE = 3'd5  // open bus, reads back 0xff
  } region_e;

  // page limits of the map, one page is 512 bytes
  localparam logic [6:0] ROM_LIMIT      = 7'h08; // first page past 0x0fff
  localparam logic [6:0] VDC_PAGE_FIRST = 7'h10; // 0x2000
  localparam logic [6:0] VDC_PAGE_LAST  = 7'h1a; // up to 0x35ff
  localparam logic [6:0] APU_PAGE       = 7'h1b; // 0x3600-0x37ff

endpackage

/* hdl/work_ram.sv */
// internal work ram of the cpu, single port with synchronous write and registered read
module work_ram #(
  parameter int unsigned WRAM_AW = 7
) (
  input  logic               CLK,
  input  logic               sel_i,   // address falls in the ram window
  input  logic               rd_i,
  input  logic               wr_i,
  input  logic [WRAM_AW-1:0] addr_i,
  input  logic [7:0]         wdata_i,
  output logic [7:0]         rdata_o
);

  localparam int unsigned DEPTH = 1 << WRAM_AW;

  logic [7:0] mem [DEPTH];

  ////////////////////
  // write port
  ////////////////////

  always_ff @(posedge CLK) begin
    if (sel_i && wr_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  ////////////////////
  // read port
  ////////////////////

  // a write lands at the edge, so the next cycle's read sees it
  always_ff @(posedge CLK) begin
    if (sel_i && rd_i) begin
      rdata_o <= mem[addr_i];
    end
  end

  // the cpu never drives both strobes at once
  rd_wr_excl_a : assert property (@(posedge CLK) !(rd_i && wr_i))
    else $error("rd_i and wr_i high together, addr_i 0x%h", addr_i);

endmodule

/* project.f */
hdl/scv_map_pkg.sv
hdl/scv_clk_pkg.sv
hdl/clock_enable_gen.sv
hdl/address_decoder.sv
hdl/boot_rom.sv
hdl/work_ram.sv
hdl/read_data_mux.sv
hdl/scv_bus.sv
dv/scv_bus_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the bus testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module scv_bus_tb \
    -f project.f -o Vscv_bus_tb > "$BUILD_LOG" 2>&1; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/Vscv_bus_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^No errors$" "$SIM_LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
